//--- compile.f
+incdir+hw
hw/usb_tx_pkg.sv
hw/usb_tx_if.sv
hw/usb_tx_cmd.sv
hw/usb_pkt_tx.sv
hw/usb_tx_top.sv
tests/usb_line_monitor.sv
tests/tb_usb_tx.sv

//--- Makefile
TOP := tb_usb_tx
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ) sim.log

//--- tests/tb_usb_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_settings.svh"

module tb_usb_tx;

  localparam int         NUM_TESTS = 12;
  localparam logic [1:0] PAT_FIXED = 2'd0;
  localparam logic [1:0] PAT_ONES  = 2'd1;
  localparam logic [1:0] PAT_RAND  = 2'd2;
  // Count marker for a random length.
  localparam logic [7:0] LEN_RAND  = 8'hFF;

  typedef struct packed {
    logic [3:0] pid;
    logic [7:0] nbytes;
    logic [1:0] pat;
    logic       refuse;
  } entry_t;

  // PID, byte count, payload pattern, refused.
  entry_t tests [NUM_TESTS] = '{
    '{usb_tx_pkg::PID_ACK,   8'd0,                 PAT_FIXED, 1'b0},
    '{usb_tx_pkg::PID_NAK,   8'd0,                 PAT_FIXED, 1'b0},
    '{usb_tx_pkg::PID_STALL, 8'd0,                 PAT_FIXED, 1'b0},
    '{usb_tx_pkg::PID_DATA0, 8'd0,                 PAT_FIXED, 1'b0},
    '{usb_tx_pkg::PID_DATA1, 8'd1,                 PAT_FIXED, 1'b0},
    '{usb_tx_pkg::PID_DATA0, 8'(`USB_MAX_PKT),     PAT_FIXED, 1'b0},
    '{usb_tx_pkg::PID_DATA1, 8'(`USB_MAX_PKT),     PAT_ONES,  1'b0},
    '{usb_tx_pkg::PID_DATA0, LEN_RAND,             PAT_RAND,  1'b0},
    // IN token, never sent by a device.
    '{4'b1001,               8'd0,                 PAT_FIXED, 1'b1},
    '{usb_tx_pkg::PID_DATA1, 8'(`USB_MAX_PKT + 1), PAT_FIXED, 1'b1},
    '{usb_tx_pkg::PID_DATA0, 8'd3,                 PAT_RAND,  1'b0},
    '{usb_tx_pkg::PID_DATA1, LEN_RAND,             PAT_RAND,  1'b0}
  };

  logic                clk;
  logic                rst;
  logic                req;
  usb_tx_pkg::pid_t    pid;
  usb_tx_pkg::nbytes_t nbytes;
  logic                wr_en;
  usb_tx_pkg::idx_t    wr_idx;
  usb_tx_pkg::byte_t   wr_byte;
  logic                ack;
  logic                err;
  logic                dp;
  logic                dn;
  logic                inflight;
  int                  mon_pkts;
  int                  mon_ferr;
  int                  mon_nonidle;
  int                  mon_len;
  usb_tx_pkg::byte_t   mon_bytes [`USB_MAX_PKT+4];
  usb_tx_pkg::byte_t   payload_q [$];
  int                  errors = 0;
  int                  test_errs;
  int                  cycles = 0;
  int                  cycle_limit;

  usb_tx_top dut (
    .i_clk_12MHz (clk),
    .i_rst       (rst),
    .i_req       (req),
    .o_ack       (ack),
    .o_err       (err),
    .i_pid       (pid),
    .i_nbytes    (nbytes),
    .i_wr_en     (wr_en),
    .i_wr_idx    (wr_idx),
    .i_wr_byte   (wr_byte),
    .o_dp        (dp),
    .o_dn        (dn),
    .o_inflight  (inflight)
  );

  usb_line_monitor mon (
    .i_clk_12MHz  (clk),
    .i_rst        (rst),
    .i_dp         (dp),
    .i_dn         (dn),
    .o_pkt_cnt    (mon_pkts),
    .o_frame_errs (mon_ferr),
    .o_nonidle    (mon_nonidle),
    .o_len        (mon_len),
    .o_bytes      (mon_bytes)
  );

  // 12 MHz nominal, 40 ns here.
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Watchdog on the whole run.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Bits on the line with worst case stuffing, plus overhead and buffer writes.
  function automatic int timeout_limit();
    int sum;
    int n;
    sum = 0;
    foreach (tests[i]) begin
      n = (tests[i].nbytes == LEN_RAND) ? `USB_MAX_PKT : int'(tests[i].nbytes);
      sum += (n + 4) * 8 * 7 / 6 + 20 + n;
    end
    return sum + 200;
  endfunction

  // CRC16 in the MSB-first form, x^16+x^15+x^2+1, seed all ones.
  function automatic logic [15:0] crc16_model(input usb_tx_pkg::byte_t data [$]);
    logic [15:0] crc;
    logic        fb;
    crc = 16'hFFFF;
    foreach (data[i]) begin
      for (int b = 0; b < 8; b++) begin
        fb  = data[i][b] ^ crc[15];
        crc = {crc[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
    end
    return crc;
  endfunction

  // CRC goes out MSB first, bytes are read LSB first.
  function automatic usb_tx_pkg::byte_t reverse_bits(input usb_tx_pkg::byte_t v);
    usb_tx_pkg::byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = v[7 - i];
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    errors++;
    test_errs++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    errors++;
    test_errs++;
  endtask

  // Fill the buffer, one byte per cycle.
  task automatic write_payload(input int n, input int t, input logic [1:0] pat);
    usb_tx_pkg::byte_t b;
    payload_q.delete();
    for (int i = 0; i < n; i++) begin
      case (pat)
        PAT_ONES: b = 8'hFF;
        PAT_RAND: b = usb_tx_pkg::byte_t'($urandom);
        default:  b = usb_tx_pkg::byte_t'(i * 29 + t * 7 + 1);
      endcase
      payload_q.push_back(b);
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_idx  <= usb_tx_pkg::idx_t'(i);
      wr_byte <= b;
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic run_test(input int t);
    entry_t            e;
    int                n;
    bit                saw_busy;
    int                pkts0;
    int                idle0;
    int                ferr0;
    logic [15:0]       crc;
    usb_tx_pkg::byte_t exp_q [$];
    e         = tests[t];
    n         = (e.nbytes == LEN_RAND) ? int'($urandom_range(1, `USB_MAX_PKT)) :
                                         int'(e.nbytes);
    test_errs = 0;
    saw_busy  = 0;
    if (!e.refuse) begin
      write_payload(n, t, e.pat);
    end
    pkts0 = mon_pkts;
    idle0 = mon_nonidle;
    ferr0 = mon_ferr;
    @(posedge clk);
    pid    <= e.pid;
    nbytes <= usb_tx_pkg::nbytes_t'(n);
    req    <= 1'b1;
    @(posedge clk);
    while (!ack) begin
      if (inflight) begin
        saw_busy = 1;
      end
      @(posedge clk);
    end
    if (err !== e.refuse) report_mismatch("o_err", int'(err), int'(e.refuse));
    if (inflight) report_error("o_inflight still high when o_ack rose");
    if ({dp, dn} != usb_tx_pkg::LINE_J) report_mismatch("line {d+,d-}", int'({dp, dn}), 2);
    if (mon_ferr != ferr0) report_error("framing or stuffing error seen on the line");
    if (e.refuse) begin
      if (saw_busy) report_error("o_inflight rose for a refused command");
      if (mon_nonidle != idle0) report_error("line left J for a refused command");
    end else begin
      if (!saw_busy) report_error("o_inflight never rose while the packet was sent");
      if (mon_pkts != pkts0 + 1) report_mismatch("packet count", mon_pkts, pkts0 + 1);
      // SYNC, then PID with its complement.
      exp_q.push_back(8'h80);
      exp_q.push_back({~e.pid, e.pid});
      if (e.pid == usb_tx_pkg::PID_DATA0 || e.pid == usb_tx_pkg::PID_DATA1) begin
        crc = ~crc16_model(payload_q);
        foreach (payload_q[i]) exp_q.push_back(payload_q[i]);
        exp_q.push_back(reverse_bits(crc[15:8]));
        exp_q.push_back(reverse_bits(crc[7:0]));
      end
      if (mon_len != exp_q.size()) begin
        report_mismatch("byte count", mon_len, exp_q.size());
      end else begin
        foreach (exp_q[i]) begin
          if (mon_bytes[i] != exp_q[i]) begin
            report_mismatch($sformatf("line byte %0d", i), int'(mon_bytes[i]), int'(exp_q[i]));
          end
        end
      end
    end
    // Host still holds i_req, block must wait in the ack phase.
    @(posedge clk);
    if (!ack) report_error("o_ack fell while i_req was still high");
    if (inflight) report_error("a packet started while o_ack was held");
    req <= 1'b0;
    @(posedge clk);
    while (ack) begin
      @(posedge clk);
    end
    $display("test %0d pid %b len %0d: %s", t, e.pid, n, (test_errs == 0) ? "ok" : "errors");
  endtask

  initial begin
    void'($urandom(54));
    rst         = 1'b1;
    req         = 1'b0;
    pid         = '0;
    nbytes      = '0;
    wr_en       = 1'b0;
    wr_idx      = '0;
    wr_byte     = '0;
    cycle_limit = timeout_limit();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // Idle state out of reset.
    test_errs = 0;
    if (ack) report_error("o_ack high after reset");
    if (err) report_error("o_err high after reset");
    if (inflight) report_error("o_inflight high after reset");
    if ({dp, dn} != usb_tx_pkg::LINE_J) report_mismatch("line {d+,d-}", int'({dp, dn}), 2);
    $display("reset state: %s", (test_errs == 0) ? "ok" : "errors");
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("summary: %0d tests, %0d errors", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/usb_line_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_settings.svh"

// Receive side model of the USB line.
// Decodes NRZI, drops stuffed zeros and collects the bytes up to SE0.
module usb_line_monitor (
  input  logic               i_clk_12MHz,
  input  logic               i_rst,
  input  logic               i_dp,
  input  logic               i_dn,
  output int                 o_pkt_cnt,
  output int                 o_frame_errs,
  output int                 o_nonidle,
  output int                 o_len,
  output usb_tx_pkg::byte_t  o_bytes [`USB_MAX_PKT+4]
);

  // 0 armed on J, 1 receiving, 2 in EOP until J.
  logic [1:0]         mode_q;
  logic [1:0]         prev_q;
  usb_tx_pkg::byte_t  sr_q;
  int                 ones_q;
  int                 nbit_q;
  int                 len_q;

  always @(posedge i_clk_12MHz) begin
    logic [1:0] cur;
    logic       b;
    cur = {i_dp, i_dn};
    // No change on the line is a one.
    b   = (cur == prev_q);
    if (i_rst) begin
      mode_q       <= 2'd0;
      prev_q       <= usb_tx_pkg::LINE_J;
      o_pkt_cnt    <= 0;
      o_frame_errs <= 0;
      o_nonidle    <= 0;
      o_len        <= 0;
    end else begin
      if (cur != usb_tx_pkg::LINE_J) begin
        o_nonidle <= o_nonidle + 1;
      end
      case (mode_q)
        2'd0: begin
          // First K is SYNC bit 0.
          if (cur == usb_tx_pkg::LINE_K) begin
            mode_q <= 2'd1;
            ones_q <= 0;
            nbit_q <= 1;
            len_q  <= 0;
            sr_q   <= 8'h00;
          end
        end
        2'd1: begin
          if (cur == usb_tx_pkg::LINE_SE0) begin
            // Leftover bits mean a broken frame.
            if (nbit_q != 0) begin
              o_frame_errs <= o_frame_errs + 1;
            end
            o_len     <= len_q;
            o_pkt_cnt <= o_pkt_cnt + 1;
            mode_q    <= 2'd2;
          end else if (ones_q == `USB_STUFF_RUN) begin
            // Stuffed bit, must be a zero.
            if (b) begin
              o_frame_errs <= o_frame_errs + 1;
            end
            ones_q <= 0;
          end else begin
            ones_q <= b ? ones_q + 1 : 0;
            sr_q   <= {b, sr_q[7:1]};
            if (nbit_q == 7) begin
              if (len_q < `USB_MAX_PKT + 4) begin
                o_bytes[len_q] <= {b, sr_q[7:1]};
              end
              len_q  <= len_q + 1;
              nbit_q <= 0;
            end else begin
              nbit_q <= nbit_q + 1;
            end
          end
        end
        default: begin
          if (cur == usb_tx_pkg::LINE_J) begin
            mode_q <= 2'd0;
          end
        end
      endcase
      prev_q <= cur;
    end
  end

endmodule

`default_nettype wire

//--- hw/usb_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module usb_tx_top (
  input  logic                 i_clk_12MHz,
  input  logic                 i_rst,

  // Four-phase request from the host side.
  input  logic                 i_req,
  output logic                 o_ack,
  output logic                 o_err,
  input  usb_tx_pkg::pid_t     i_pid,
  input  usb_tx_pkg::nbytes_t  i_nbytes,

  // Payload buffer writes, only while not in flight.
  input  logic                 i_wr_en,
  input  usb_tx_pkg::idx_t     i_wr_idx,
  input  usb_tx_pkg::byte_t    i_wr_byte,

  // USB {d+, d-} and output enable.
  output logic                 o_dp,
  output logic                 o_dn,
  output logic                 o_inflight
);

  usb_tx_if u_tx_if ();

  usb_tx_cmd u_cmd (
    .i_clk_12MHz (i_clk_12MHz),
    .i_rst       (i_rst),
    .i_req       (i_req),
    .i_pid       (i_pid),
    .i_nbytes    (i_nbytes),
    .o_ack       (o_ack),
    .o_err       (o_err),
    .tx          (u_tx_if.cmd)
  );

  usb_pkt_tx u_pkt_tx (
    .i_clk_12MHz (i_clk_12MHz),
    .i_rst       (i_rst),
    .rx          (u_tx_if.ser),
    .i_wr_en     (i_wr_en),
    .i_wr_idx    (i_wr_idx),
    .i_wr_byte   (i_wr_byte),
    .o_dp        (o_dp),
    .o_dn        (o_dn),
    .o_inflight  (o_inflight)
  );

endmodule

`default_nettype wire

//--- hw/usb_pkt_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_settings.svh"

module usb_pkt_tx (
  input  logic                 i_clk_12MHz,
  input  logic                 i_rst,
  usb_tx_if.ser                rx,
  input  logic                 i_wr_en,
  input  usb_tx_pkg::idx_t     i_wr_idx,
  input  usb_tx_pkg::byte_t    i_wr_byte,
  output logic                 o_dp,
  output logic                 o_dn,
  output logic                 o_inflight
);

  usb_tx_pkg::byte_t        pkt_mem [`USB_MAX_PKT];
  usb_tx_pkg::pid_t         pid_q;
  usb_tx_pkg::nbytes_t      nbytes_q;
  usb_tx_pkg::nbytes_t      byte_cnt_q;
  usb_tx_pkg::idx_t         rd_idx;
  usb_tx_pkg::byte_t        shift_q;
  usb_tx_pkg::byte_t        next_byte;
  usb_tx_pkg::crc16_t       crc_q;
  usb_tx_pkg::crc16_t       crc_d;
  usb_tx_pkg::line_e        line_q;
  logic [2:0]               bit_cnt_q;
  logic [2:0]               tail_q;
  logic [`USB_STUFF_RUN-1:0] hist_q;
  logic is_data;
  logic is_hs;
  logic accept;
  logic inflight_q;
  logic stuff;
  logic send_bit;
  logic bit_step;
  logic stuff_step;
  logic byte_done;
  logic last_payload;
  logic final_byte;
  logic crc_en;
  logic crc_loop;
  logic bytes_done_q;
  logic eop_q;
  logic eop_start;
  logic eop_done;

  // Host fills the buffer before the request.
  always_ff @(posedge i_clk_12MHz) begin
    if (i_wr_en) begin
      pkt_mem[i_wr_idx] <= i_wr_byte;
    end
  end

  assign accept      = rx.valid && rx.ready;
  assign rx.ready    = !inflight_q;
  assign rx.eop_done = eop_done;
  assign o_inflight  = inflight_q;

  // Command latched on the accept.
  always_ff @(posedge i_clk_12MHz) begin
    if (accept) begin
      pid_q    <= rx.pid;
      nbytes_q <= rx.nbytes;
    end
  end

  assign is_data = (usb_tx_pkg::pid_grp_e'(pid_q[1:0]) == usb_tx_pkg::GRP_DATA);
  assign is_hs   = (usb_tx_pkg::pid_grp_e'(pid_q[1:0]) == usb_tx_pkg::GRP_HANDSHAKE);

  // Stuff after a full run of ones.
  assign stuff    = &hist_q;
  assign send_bit = shift_q[0] && !stuff;

  // Real bit goes out. The accept cycle already sends SYNC bit 0.
  assign bit_step   = (accept || (inflight_q && !bytes_done_q)) && !stuff;
  // Stuffed zero, also possible after the final byte.
  assign stuff_step = inflight_q && !eop_q && stuff;
  assign byte_done  = bit_step && (bit_cnt_q == 3'd7);

  // The byte now finishing is PID or the last payload byte.
  assign last_payload = is_data && (byte_cnt_q == nbytes_q + usb_tx_pkg::nbytes_t'(1));
  assign final_byte   = byte_done && (is_hs ? (byte_cnt_q == usb_tx_pkg::nbytes_t'(1)) :
                                              tail_q[1]);

  assign eop_start = inflight_q && bytes_done_q && !eop_q && !stuff;
  assign eop_done  = eop_q && (bit_cnt_q == 3'd2);

  // Bit counter also times SE0, SE0, J.
  always_ff @(posedge i_clk_12MHz) begin
    if (i_rst || eop_done) begin
      bit_cnt_q <= '0;
    end else if (bit_step || eop_q) begin
      bit_cnt_q <= bit_cnt_q + 3'd1;
    end
  end

  // Bytes on the line, SYNC included.
  always_ff @(posedge i_clk_12MHz) begin
    if (i_rst || accept) begin
      byte_cnt_q <= '0;
    end else if (byte_done) begin
      byte_cnt_q <= byte_cnt_q + usb_tx_pkg::nbytes_t'(1);
    end
  end

  // Tail sequencer: CRC low, CRC high, then EOP.
  always_ff @(posedge i_clk_12MHz) begin
    if (i_rst || accept) begin
      tail_q <= '0;
    end else if (byte_done) begin
      tail_q <= {tail_q[1:0], last_payload};
    end
  end

  // CRC16 over payload bits only.
  // Reflected form of x^16+x^15+x^2+1.
  assign crc_en   = bit_step && is_data && (byte_cnt_q >= usb_tx_pkg::nbytes_t'(2)) &&
                    (tail_q == '0);
  assign crc_loop = shift_q[0] ^ crc_q[0];

  always_comb begin
    crc_d = crc_q;
    if (crc_en) begin
      crc_d = {1'b0, crc_q[15:1]} ^ (crc_loop ? 16'hA001 : 16'h0000);
    end
  end

  // Seed of all ones.
  always_ff @(posedge i_clk_12MHz) begin
    if (accept) begin
      crc_q <= '1;
    end else begin
      crc_q <= crc_d;
    end
  end

  // Byte that follows the one finishing.
  always_comb begin
    rd_idx = usb_tx_pkg::idx_t'(byte_cnt_q - usb_tx_pkg::nbytes_t'(1));
    if (byte_cnt_q == '0) begin
      next_byte = {~pid_q, pid_q};
    end else if (last_payload) begin
      // Includes the last payload bit of this cycle.
      next_byte = ~crc_d[7:0];
    end else if (tail_q[0]) begin
      next_byte = ~crc_q[15:8];
    end else begin
      next_byte = pkt_mem[rd_idx];
    end
  end

  // LSB is the bit on the wire, SYNC waits here while idle.
  always_ff @(posedge i_clk_12MHz) begin
    if (i_rst || eop_done) begin
      shift_q <= usb_tx_pkg::SYNC_BYTE;
    end else if (byte_done) begin
      shift_q <= next_byte;
    end else if (bit_step) begin
      shift_q <= shift_q >> 1;
    end
  end

  // Sent-bit history, stuffed zeros count.
  always_ff @(posedge i_clk_12MHz) begin
    if (i_rst || eop_done) begin
      hist_q <= '0;
    end else if (bit_step || stuff_step) begin
      hist_q <= {hist_q[`USB_STUFF_RUN-2:0], send_bit};
    end
  end

  always_ff @(posedge i_clk_12MHz) begin
    if (i_rst) begin
      inflight_q   <= 1'b0;
      bytes_done_q <= 1'b0;
      eop_q        <= 1'b0;
    end else begin
      if (accept) begin
        inflight_q <= 1'b1;
      end else if (eop_done) begin
        inflight_q <= 1'b0;
      end
      if (final_byte) begin
        bytes_done_q <= 1'b1;
      end else if (eop_done) begin
        bytes_done_q <= 1'b0;
      end
      if (eop_start) begin
        eop_q <= 1'b1;
      end else if (eop_done) begin
        eop_q <= 1'b0;
      end
    end
  end

  // NRZI, a zero flips the line.
  // EOP is two SE0 cycles and one J.
  always_ff @(posedge i_clk_12MHz) begin
    if (i_rst) begin
      line_q <= usb_tx_pkg::LINE_J;
    end else if (eop_q && (bit_cnt_q == 3'd1)) begin
      line_q <= usb_tx_pkg::LINE_J;
    end else if (eop_start) begin
      line_q <= usb_tx_pkg::LINE_SE0;
    end else if ((bit_step || stuff_step) && !send_bit) begin
      line_q <= (line_q == usb_tx_pkg::LINE_J) ? usb_tx_pkg::LINE_K : usb_tx_pkg::LINE_J;
    end
  end

  assign {o_dp, o_dn} = line_q;

  // SYNC and PID for a handshake.
  a_len_hs: assert property (@(posedge i_clk_12MHz) disable iff (i_rst)
    (eop_done && is_hs) |-> (byte_cnt_q == usb_tx_pkg::nbytes_t'(2)));

  // SYNC, PID, payload and two CRC bytes.
  a_len_data: assert property (@(posedge i_clk_12MHz) disable iff (i_rst)
    (eop_done && is_data) |-> (byte_cnt_q == nbytes_q + usb_tx_pkg::nbytes_t'(4)));

  // Host keeps off the buffer while a packet is out.
  a_no_wr_inflight: assert property (@(posedge i_clk_12MHz) disable iff (i_rst)
    i_wr_en |-> !inflight_q);

endmodule

`default_nettype wire

//--- hw/usb_tx_cmd.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_settings.svh"

module usb_tx_cmd (
  input  logic                 i_clk_12MHz,
  input  logic                 i_rst,
  input  logic                 i_req,
  input  usb_tx_pkg::pid_t     i_pid,
  input  usb_tx_pkg::nbytes_t  i_nbytes,
  output logic                 o_ack,
  output logic                 o_err,
  usb_tx_if.cmd                tx
);

  usb_tx_pkg::cmd_state_e state_q;
  logic req_is_data;
  logic pid_ok;
  logic size_ok;
  logic req_legal;

  // Only the five device-to-host PIDs are sent.
  assign pid_ok = (i_pid == usb_tx_pkg::PID_DATA0) || (i_pid == usb_tx_pkg::PID_DATA1) ||
                  (i_pid == usb_tx_pkg::PID_ACK)   || (i_pid == usb_tx_pkg::PID_NAK)   ||
                  (i_pid == usb_tx_pkg::PID_STALL);

  assign req_is_data = (usb_tx_pkg::pid_grp_e'(i_pid[1:0]) == usb_tx_pkg::GRP_DATA);

  // Count matters for data only.
  assign size_ok   = !req_is_data || (i_nbytes <= usb_tx_pkg::nbytes_t'(`USB_MAX_PKT));
  assign req_legal = pid_ok && size_ok;

  // Four-phase exchange with the host.
  always_ff @(posedge i_clk_12MHz) begin
    if (i_rst) begin
      state_q  <= usb_tx_pkg::CMD_IDLE;
      tx.valid <= 1'b0;
      o_ack    <= 1'b0;
      o_err    <= 1'b0;
    end else begin
      case (state_q)
        usb_tx_pkg::CMD_IDLE: begin
          if (i_req && req_legal) begin
            tx.valid <= 1'b1;
            state_q  <= usb_tx_pkg::CMD_SEND;
          end else if (i_req) begin
            // Refused, nothing goes on the line.
            o_ack   <= 1'b1;
            o_err   <= 1'b1;
            state_q <= usb_tx_pkg::CMD_ACK;
          end
        end
        usb_tx_pkg::CMD_SEND: begin
          // Drop valid on the accept.
          if (tx.ready) begin
            tx.valid <= 1'b0;
          end
          if (tx.eop_done) begin
            o_ack   <= 1'b1;
            o_err   <= 1'b0;
            state_q <= usb_tx_pkg::CMD_ACK;
          end
        end
        usb_tx_pkg::CMD_ACK: begin
          // Held here while the host keeps i_req high.
          if (!i_req) begin
            o_ack   <= 1'b0;
            state_q <= usb_tx_pkg::CMD_IDLE;
          end
        end
        default: state_q <= usb_tx_pkg::CMD_IDLE;
      endcase
    end
  end

  // Command fields, captured on the request.
  // Handshakes carry no payload.
  always_ff @(posedge i_clk_12MHz) begin
    if ((state_q == usb_tx_pkg::CMD_IDLE) && i_req) begin
      tx.pid    <= i_pid;
      tx.nbytes <= req_is_data ? i_nbytes : '0;
    end
  end

  // Done is only reported once the command has left the interface.
  a_ack_after_accept: assert property (@(posedge i_clk_12MHz) disable iff (i_rst)
    $rose(o_ack) |-> !tx.valid);

  // Command stays put until the serializer takes it.
  a_valid_held: assert property (@(posedge i_clk_12MHz) disable iff (i_rst)
    (tx.valid && !tx.ready) |=> (tx.valid && $stable(tx.pid) && $stable(tx.nbytes)));

endmodule

`default_nettype wire

//--- hw/usb_tx_if.sv
`timescale 1ns/1ps
`default_nettype none

// Packet command from the command block to the serializer.
// Valid/ready, the accept is the cycle with both high.
interface usb_tx_if;

  // Command side.
  logic                   valid;
  usb_tx_pkg::pid_t       pid;
  usb_tx_pkg::nbytes_t    nbytes;

  // Serializer side.
  logic                   ready;
  // One-cycle pulse in the J cycle after SE0.
  logic                   eop_done;

  modport cmd (
    output valid, pid, nbytes,
    input  ready, eop_done
  );

  modport ser (
    input  valid, pid, nbytes,
    output ready, eop_done
  );

endinterface

`default_nettype wire

//--- hw/usb_tx_pkg.sv
`default_nettype none

`include "usb_tx_settings.svh"

package usb_tx_pkg;

  // Plain vectors with a meaning.
  typedef logic [7:0]                byte_t;
  typedef logic [3:0]                pid_t;
  typedef logic [`USB_NBYTES_W-1:0]  nbytes_t;
  typedef logic [`USB_IDX_W-1:0]     idx_t;
  typedef logic [15:0]               crc16_t;

  // PIDs that a device may send (USB 2.0 table 8-1).
  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;
  localparam pid_t PID_ACK   = 4'b0010;
  localparam pid_t PID_NAK   = 4'b1010;
  localparam pid_t PID_STALL = 4'b1110;

  // Coding group, taken from the two low PID bits.
  typedef enum logic [1:0] {GRP_HANDSHAKE = 2'b10, GRP_DATA = 2'b11} pid_grp_e;

  // Line state as {d+, d-}.
  typedef enum logic [1:0] {LINE_SE0 = 2'b00, LINE_K = 2'b01, LINE_J = 2'b10} line_e;

  // Command block FSM.
  typedef enum logic [1:0] {CMD_IDLE, CMD_SEND, CMD_ACK} cmd_state_e;

  // SYNC is seven zeros then a one, LSB first.
  localparam byte_t SYNC_BYTE = 8'h80;

endpackage

`default_nettype wire

//--- hw/usb_tx_settings.svh
`ifndef USB_TX_SETTINGS_SVH
`define USB_TX_SETTINGS_SVH

// Largest payload in bytes (wMaxPacketSize).
// Full speed allows 8, 16, 32 or 64.
`define USB_MAX_PKT 8

// Payload buffer index width.
`define USB_IDX_W $clog2(`USB_MAX_PKT)

// Byte count width, must hold USB_MAX_PKT itself.
`define USB_NBYTES_W $clog2(`USB_MAX_PKT + 1)

// Run of ones after which a zero is stuffed.
// Fixed at 6 by the USB 2.0 line coding.
`define USB_STUFF_RUN 6

`endif
